// ==== common/hazard_macros.svh ====
// hazard unit sizing
// register file geometry and the length of a fetch redirect

`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// register address width, x0..x31
`define HZ_REG_AW 5

// architectural register count, must equal 2**HZ_REG_AW
`define HZ_REG_NUM 32

// cycles of fetch squash per redirect
// one resolving cycle plus one added by the registered fetch address
`define HZ_REDIRECT_CYCLES 2

`endif

// ==== common/hazard_pkg.sv ====
// hazard unit shared types
// write-back, control-flow and bypass encodings, plus the packed
// words exchanged between the pipeline stages and the hazard unit

`include "hazard_macros.svh"

package hazard_pkg;

  typedef logic [`HZ_REG_AW-1:0] reg_addr_t;  // architectural register index

  // write-back source of an instruction
  typedef enum logic [1:0] {
    wb_none = 2'd0,  // no register write
    wb_alu  = 2'd1,  // alu result
    wb_pc4  = 2'd2,  // link address of jal/jalr
    wb_dmem = 2'd3   // load data, only ready after MA
  } wb_sel_e;

  // control-flow kind of an instruction
  typedef enum logic [1:0] {
    br_none = 2'd0,  // sequential
    br_jal  = 2'd1,  // target known in ID
    br_jalr = 2'd2,  // target computed in EX
    br_cond = 2'd3   // outcome known in EX
  } br_sel_e;

  // operand source for the instruction in ID
  typedef enum logic [1:0] {
    bp_rf = 2'd0,  // register file read
    bp_ex = 2'd1,  // EX result
    bp_ma = 2'd2,  // MA result
    bp_wb = 2'd3   // WB result
  } bp_sel_e;

  typedef struct packed {
    reg_addr_t rd;      // destination register
    wb_sel_e   sel_wb;  // what gets written, wb_none if nothing
  } stage_wb_t;

  typedef struct packed {
    reg_addr_t rs1;       // always read
    reg_addr_t rs2;
    logic      rs2_used;  // rs2 read by this opcode
  } src_regs_t;

  typedef struct packed {
    logic squash_if;  // kill the instruction in IF
    logic squash_id;  // kill the instruction in ID
    logic squash_ex;  // insert a bubble into EX
    logic en_fetch;   // IF/ID advance
    logic update_pc;  // PC register load
  } hz_ctrl_t;

endpackage

// ==== design/operand_bypass.sv ====
// operand bypass
// matches one ID source register against the EX, MA and WB writers,
// picks the youngest producer and flags a load that is still in EX

`timescale 1ns/100ps

`include "hazard_macros.svh"

module operand_bypass
  import hazard_pkg::*;
(
  input  reg_addr_t i_addr,     // source register of the ID instruction
  input  logic      i_used,     // operand actually read
  input  stage_wb_t i_wb_ex,    // writer in EX
  input  stage_wb_t i_wb_ma,    // writer in MA
  input  stage_wb_t i_wb_wb,    // writer in WB
  output bp_sel_e   o_bp_sel,   // operand source
  output logic      o_load_use  // load in EX feeds this operand
);

  logic need;    // operand can depend on a producer at all
  logic hit_ex;  // youngest producer
  logic hit_ma;
  logic hit_wb;  // oldest producer still in flight
  logic ex_load; // EX result comes from data memory

  // the address width has to cover the whole register file
  if ((1 << `HZ_REG_AW) != `HZ_REG_NUM) begin : g_aw_check
    $error("register address width does not match the register count");
  end

  // a stage produces this operand when it writes the same register
  function automatic logic writes_to(input stage_wb_t stg, input reg_addr_t addr);
    logic wr;
    wr = (stg.sel_wb != wb_none);  // stage has a destination
    return wr && (stg.rd == addr);
  endfunction

  assign need    = i_used && (i_addr != '0);  // x0 is hardwired, never bypassed
  assign hit_ex  = need && writes_to(i_wb_ex, i_addr);
  assign hit_ma  = need && writes_to(i_wb_ma, i_addr);
  assign hit_wb  = need && writes_to(i_wb_wb, i_addr);
  assign ex_load = (i_wb_ex.sel_wb == wb_dmem);

  // youngest writer wins, older matches hold stale values
  always_comb begin
    o_bp_sel   = bp_rf;
    o_load_use = 1'b0;
    if (hit_ex) begin
      if (ex_load) begin
        o_load_use = 1'b1;   // data not out of memory yet, stall instead
      end else begin
        o_bp_sel   = bp_ex;
      end
    end else if (hit_ma) begin
      o_bp_sel = bp_ma;
    end else if (hit_wb) begin
      o_bp_sel = bp_wb;
    end
  end

  // a load in EX has no value to forward, whatever else matched
  always_comb begin
    a_no_ex_load_bypass: assert final (!(o_bp_sel == bp_ex && ex_load))
      else $error("EX bypass selected while EX reads data memory");
  end

endmodule

// ==== design/flow_ctrl.sv ====
// pipeline flow control
// resolves EX redirects (jalr, taken branch) and ID jal, holds their
// extra squash cycle, detects load-use stalls and gates PC updates
// priority is EX redirect, then load-use stall, then jal

`timescale 1ns/100ps

`include "hazard_macros.svh"

module flow_ctrl
  import hazard_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,           // sync, active high
  input  logic     i_load_use_rs1,  // rs1 waits on a load in EX
  input  logic     i_load_use_rs2,  // rs2 waits on a load in EX
  input  br_sel_e  i_br_id,         // control-flow kind in ID
  input  br_sel_e  i_br_ex,         // control-flow kind in EX
  input  logic     i_taken_ex,      // branch outcome in EX
  output hz_ctrl_t o_ctrl
);

  // cycles held after the resolving one
  localparam int unsigned REDIR_HOLD = `HZ_REDIRECT_CYCLES - 1;

  logic                  redir_ex_now;  // redirect resolved this cycle
  logic [REDIR_HOLD-1:0] redir_hold_q;  // trailing redirect cycles
  logic                  redir_held;
  logic                  redir_win;     // any EX redirect squash active

  logic                  load_use;      // either operand waits on a load
  logic                  stall;

  logic                  jal_now;       // jal accepted this cycle
  logic [REDIR_HOLD-1:0] jal_hold_q;    // trailing jal cycles
  logic                  jal_held;

  logic                  rst_q;         // first cycle out of reset

  // jalr always leaves, a conditional branch only when taken
  assign redir_ex_now = (i_br_ex == br_jalr) ||
                        ((i_br_ex == br_cond) && i_taken_ex);
  assign redir_held   = |redir_hold_q;
  assign redir_win    = redir_ex_now || redir_held;

  // the ID instruction may be on the wrong path during a redirect
  assign load_use = i_load_use_rs1 || i_load_use_rs2;
  assign stall    = load_use && !redir_win;

  // a stalled jal retries next cycle, a wrong-path one is dropped
  assign jal_now  = (i_br_id == br_jal) && !redir_win && !stall;
  assign jal_held = (|jal_hold_q) && !redir_ex_now;  // EX redirect overrides

  // delay lines for the registered fetch address
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      redir_hold_q <= '0;
      jal_hold_q   <= '0;
    end else begin
      redir_hold_q[0] <= redir_ex_now;
      jal_hold_q[0]   <= jal_now;
      for (int i = 1; i < REDIR_HOLD; i++) begin
        redir_hold_q[i] <= redir_hold_q[i-1];
        jal_hold_q[i]   <= jal_hold_q[i-1] && !redir_ex_now;  // cancelled by redirect
      end
    end
  end

  // follows reset by one cycle, PC stays put while fetch restarts
  always_ff @(posedge i_clk) begin
    rst_q <= i_rst;
  end

  always_comb begin
    o_ctrl.squash_if = redir_win || jal_now || jal_held;
    o_ctrl.squash_id = redir_win;                    // ID is wrong-path
    o_ctrl.squash_ex = stall;                        // bubble behind the load
    o_ctrl.en_fetch  = !stall;                       // freeze IF/ID
    o_ctrl.update_pc = !stall && !i_rst && !rst_q;
  end

  // a redirect's held cycle must never carry a stall bubble
  a_no_stall_after_redirect: assert property (
    @(posedge i_clk) disable iff (i_rst)
    redir_ex_now |=> !o_ctrl.squash_ex
  ) else $error("stall signalled inside an EX redirect window");

  a_no_stall_with_redirect: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_ctrl.squash_ex |-> !o_ctrl.squash_id
  ) else $error("stall and EX redirect squash together");

  // fetch freezes only while a bubble goes into EX
  a_fetch_vs_bubble: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_ctrl.en_fetch != o_ctrl.squash_ex
  ) else $error("en_fetch and squash_ex out of step");

endmodule

// ==== design/hazard_unit.sv ====
// hazard unit top
// two operand bypass checkers for the ID sources feeding one flow
// controller that owns squash, stall and PC-update control

`timescale 1ns/100ps

module hazard_unit
  import hazard_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,       // sync, active high
  input  src_regs_t i_src_id,    // sources of the ID instruction
  input  stage_wb_t i_wb_ex,     // destination in EX
  input  stage_wb_t i_wb_ma,     // destination in MA
  input  stage_wb_t i_wb_wb,     // destination in WB
  input  br_sel_e   i_br_id,     // jal resolves here
  input  br_sel_e   i_br_ex,     // jalr and branches resolve here
  input  logic      i_taken_ex,  // branch outcome in EX
  output bp_sel_e   o_bp_rs1,    // rs1 operand source
  output bp_sel_e   o_bp_rs2,    // rs2 operand source
  output hz_ctrl_t  o_ctrl       // squash, enable and PC control
);

  logic load_use_rs1;  // rs1 depends on a load still in EX
  logic load_use_rs2;  // rs2 depends on a load still in EX

  // rs1 is read by every format that has it
  operand_bypass u_bypass_rs1 (
    .i_addr     (i_src_id.rs1),
    .i_used     (1'b1),
    .i_wb_ex    (i_wb_ex),
    .i_wb_ma    (i_wb_ma),
    .i_wb_wb    (i_wb_wb),
    .o_bp_sel   (o_bp_rs1),
    .o_load_use (load_use_rs1)
  );

  // rs2 only for R, S and B formats
  operand_bypass u_bypass_rs2 (
    .i_addr     (i_src_id.rs2),
    .i_used     (i_src_id.rs2_used),
    .i_wb_ex    (i_wb_ex),
    .i_wb_ma    (i_wb_ma),
    .i_wb_wb    (i_wb_wb),
    .o_bp_sel   (o_bp_rs2),
    .o_load_use (load_use_rs2)
  );

  flow_ctrl u_flow_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_load_use_rs1 (load_use_rs1),
    .i_load_use_rs2 (load_use_rs2),
    .i_br_id        (i_br_id),
    .i_br_ex        (i_br_ex),
    .i_taken_ex     (i_taken_ex),
    .o_ctrl         (o_ctrl)
  );

endmodule

// ==== verification/tb_hazard.sv ====
// hazard unit testbench
// seeded random pipeline traffic against a cycle model of the bypass,
// stall, redirect, jal and reset rules, checked before every rising edge

`timescale 1ns/100ps

module tb_hazard
  import hazard_pkg::*;
();

  localparam int RESET_CYCLES   = 3;
  localparam int IDLE_CYCLES    = 4;     // quiet cycles right after reset
  localparam int RAND_CYCLES    = 2000;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + IDLE_CYCLES + RAND_CYCLES;
  localparam int TIMEOUT_CYCLES = 2100;  // full run plus a small margin

  logic      i_clk;
  logic      i_rst;
  src_regs_t src_id;
  stage_wb_t wb_ex;
  stage_wb_t wb_ma;
  stage_wb_t wb_wb;
  br_sel_e   br_id;
  br_sel_e   br_ex;
  logic      taken_ex;
  bp_sel_e   bp_rs1;
  bp_sel_e   bp_rs2;
  hz_ctrl_t  ctrl;

  int seed;
  int error_cnt;
  int check_cnt;
  int cycle_cnt;   // watchdog count of rising edges

  // model state, mirrors the registers of the pipeline control
  logic m_redir_q;       // second cycle of an EX redirect window
  logic m_jal_q;         // second cycle of a jal window
  logic m_rst_q;         // cycle right after reset
  logic exp_redir_now;   // EX redirect seen in the checked cycle
  logic exp_jal_now;     // jal accepted in the checked cycle
  logic cur_rst;         // reset level in the checked cycle

  hazard_unit u_dut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_src_id   (src_id),
    .i_wb_ex    (wb_ex),
    .i_wb_ma    (wb_ma),
    .i_wb_wb    (wb_wb),
    .i_br_id    (br_id),
    .i_br_ex    (br_ex),
    .i_taken_ex (taken_ex),
    .o_bp_rs1   (bp_rs1),
    .o_bp_rs2   (bp_rs2),
    .o_ctrl     (ctrl)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;  // 4 ns period

  // mostly x0..x3 so producers and consumers collide often
  function automatic reg_addr_t pick_reg(input int rnd);
    if (rnd[3:0] < 4'd12) begin
      return {3'b000, rnd[5:4]};
    end
    return rnd[12:8];
  endfunction

  // youngest producer first, a load in EX forces a stall instead
  function automatic bp_sel_e model_bypass(input reg_addr_t addr, input logic used,
                                           input stage_wb_t ex, input stage_wb_t ma,
                                           input stage_wb_t wb, output logic lu);
    lu = 1'b0;
    if (!used || addr == '0) begin
      return bp_rf;
    end
    if (ex.sel_wb != wb_none && ex.rd == addr) begin
      if (ex.sel_wb == wb_dmem) begin
        lu = 1'b1;
        return bp_rf;
      end
      return bp_ex;
    end
    if (ma.sel_wb != wb_none && ma.rd == addr) return bp_ma;
    if (wb.sel_wb != wb_none && wb.rd == addr) return bp_wb;
    return bp_rf;
  endfunction

  task automatic drive_idle();
    src_id   = '0;
    wb_ex    = '{rd: '0, sel_wb: wb_none};
    wb_ma    = '{rd: '0, sel_wb: wb_none};
    wb_wb    = '{rd: '0, sel_wb: wb_none};
    br_id    = br_none;
    br_ex    = br_none;
    taken_ex = 1'b0;
  endtask

  task automatic drive_random();
    int r;
    src_id.rs1      = pick_reg($random(seed));
    src_id.rs2      = pick_reg($random(seed));
    r               = $random(seed);
    src_id.rs2_used = r[0];
    wb_ex.rd        = pick_reg($random(seed));
    wb_ma.rd        = pick_reg($random(seed));
    wb_wb.rd        = pick_reg($random(seed));
    r               = $random(seed);
    wb_ex.sel_wb    = wb_sel_e'(r[1:0]);
    wb_ma.sel_wb    = wb_sel_e'(r[3:2]);
    wb_wb.sel_wb    = wb_sel_e'(r[5:4]);
    r               = $random(seed);
    br_ex           = (r[2:0] < 3'd5) ? br_none : br_sel_e'(r[4:3]);  // redirects sparse
    br_id           = (r[7:5] < 3'd4) ? br_none : br_sel_e'(r[9:8]);
    taken_ex        = r[12];
  endtask

  task automatic apply_stimulus(input int n);
    if (n < RESET_CYCLES) begin
      i_rst = 1'b1;
      drive_idle();
    end else if (n < RESET_CYCLES + IDLE_CYCLES) begin
      i_rst = 1'b0;
      drive_idle();
    end else begin
      i_rst = 1'b0;
      drive_random();
    end
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_cnt++;
    assert (act === exp) else begin
      error_cnt++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // model of one cycle, compared with the settled DUT outputs
  task automatic check_outputs(input int n);
    logic     lu1;
    logic     lu2;
    logic     win;
    logic     stall;
    logic     jal_hold;
    bp_sel_e  exp_bp1;
    bp_sel_e  exp_bp2;
    hz_ctrl_t exp_ctrl;
    cur_rst       = i_rst;
    exp_bp1       = model_bypass(src_id.rs1, 1'b1, wb_ex, wb_ma, wb_wb, lu1);
    exp_bp2       = model_bypass(src_id.rs2, src_id.rs2_used, wb_ex, wb_ma, wb_wb, lu2);
    exp_redir_now = (br_ex == br_jalr) || (br_ex == br_cond && taken_ex);
    win           = exp_redir_now || m_redir_q;  // EX redirect window
    stall         = (lu1 || lu2) && !win;
    exp_jal_now   = (br_id == br_jal) && !win && !stall;
    jal_hold      = m_jal_q && !exp_redir_now;   // new redirect overrides
    exp_ctrl.squash_if = win || exp_jal_now || jal_hold;
    exp_ctrl.squash_id = win;
    exp_ctrl.squash_ex = stall;
    exp_ctrl.en_fetch  = !stall;
    exp_ctrl.update_pc = !stall && !cur_rst && !m_rst_q;
    check_value("o_ctrl.update_pc", 8'(exp_ctrl.update_pc), 8'(ctrl.update_pc));
    if (cur_rst) begin
      return;  // delay line not yet cleared before the first edge
    end
    check_value("o_bp_rs1", 8'(exp_bp1), 8'(bp_rs1));
    check_value("o_bp_rs2", 8'(exp_bp2), 8'(bp_rs2));
    check_value("o_ctrl.squash_if", 8'(exp_ctrl.squash_if), 8'(ctrl.squash_if));
    check_value("o_ctrl.squash_id", 8'(exp_ctrl.squash_id), 8'(ctrl.squash_id));
    check_value("o_ctrl.squash_ex", 8'(exp_ctrl.squash_ex), 8'(ctrl.squash_ex));
    check_value("o_ctrl.en_fetch", 8'(exp_ctrl.en_fetch), 8'(ctrl.en_fetch));
    if (n < RESET_CYCLES + IDLE_CYCLES) begin
      check_cnt++;
      assert (!ctrl.squash_if && !ctrl.squash_id && !ctrl.squash_ex && ctrl.en_fetch)
        else begin
          error_cnt++;
          $display("pipeline not quiet with idle inputs after reset in cycle %0d", n);
        end
    end
  endtask

  // register update of the model at the rising edge
  task automatic advance_model();
    if (cur_rst) begin
      m_redir_q = 1'b0;
      m_jal_q   = 1'b0;
    end else begin
      m_redir_q = exp_redir_now;
      m_jal_q   = exp_jal_now;
    end
    m_rst_q = cur_rst;
  endtask

  initial begin : main
    int n;
    seed          = 76;
    error_cnt     = 0;
    check_cnt     = 0;
    m_redir_q     = 1'b0;
    m_jal_q       = 1'b0;
    m_rst_q       = 1'b1;
    exp_redir_now = 1'b0;
    exp_jal_now   = 1'b0;
    cur_rst       = 1'b1;
    apply_stimulus(0);  // reset from time zero
    #1;
    for (n = 0; n < TOTAL_CYCLES; n++) begin
      check_outputs(n);   // 1 ns before the edge
      @(posedge i_clk);
      advance_model();
      #1;
      apply_stimulus(n + 1);
      #2;
    end
    $display("checks %0d errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+common
common/hazard_pkg.sv
design/operand_bypass.sv
design/flow_ctrl.sv
design/hazard_unit.sv
verification/tb_hazard.sv

// ==== Makefile ====
# Verilator build and run of the hazard unit testbench

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_hazard
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
